// File: source/pad_tap_config.svh
`ifndef PAD_TAP_CONFIG_SVH
`define PAD_TAP_CONFIG_SVH

// buttons on one pad, dpad included
`define PAD_BUTTONS 12

// one port as the console sees it, four nibbles, active low
`define PAD_CODE_W 16

// joypad data lines back to the console
`define NIBBLE_W 4

// ports with a pad behind them
`define TAP_PORTS 4

// port counter, wraps after eight sel edges
`define TAP_PORT_W 3

// turbo counter, steps on clr rising edges
`define TURBO_CNT_W 4
`define TURBO_SLOW_BIT 2
`define TURBO_FAST_BIT 1

`endif

// File: source/pad_tap_pkg.sv
`default_nettype none

`include "pad_tap_config.svh"

package pad_tap_pkg;

  // one pad, active high, msb first
  typedef struct packed {
    logic btn_6;
    logic btn_5;
    logic btn_4;
    logic btn_3;
    logic start;
    logic select;
    logic btn_2;
    logic btn_1;
    logic up;
    logic down;
    logic left;
    logic right;
  } pad_word_t;

  // console order, active low, top nibble always reads zero
  typedef logic [`PAD_CODE_W-1:0] pad_code_t;

  // scan position, only the first four have pads
  typedef enum logic [`TAP_PORT_W-1:0] {
    PORT_1 = 3'd0,
    PORT_2 = 3'd1,
    PORT_3 = 3'd2,
    PORT_4 = 3'd3,
    PORT_5 = 3'd4,
    PORT_6 = 3'd5,
    PORT_7 = 3'd6,
    PORT_8 = 3'd7
  } tap_port_e;

  // extended bank carries buttons 3 to 6
  typedef enum logic {
    BANK_STD = 1'b0,
    BANK_EXT = 1'b1
  } pad_bank_e;

  // last code behaves as off
  typedef enum logic [1:0] {
    TURBO_OFF     = 2'd0,
    TURBO_SLOW    = 2'd1,
    TURBO_FAST    = 2'd2,
    TURBO_OFF_ALT = 2'd3
  } turbo_speed_e;

endpackage

`default_nettype wire

// File: source/tap_scan_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

`include "pad_tap_config.svh"

module tap_scan_ctrl (
  input  wire                          clk_sys_42_95,
  input  wire                          arst_n,
  // console strobe lines
  input  wire                          clr,
  input  wire                          sel,
  // settings
  input  wire                          tap_enable,
  input  wire                          six_button_enable,
  // to the datapath
  output pad_tap_pkg::tap_port_e       port_sel,
  output logic [1:0]                   nibble_idx,
  output logic                         nibble_clear,
  output logic [`TURBO_CNT_W-1:0]      turbo_count
);

  // previous console levels
  logic clr_q;
  logic sel_q;

  // edges against the stored level
  logic clr_rise;
  logic sel_rise;
  logic port_step;

  // scan state
  pad_tap_pkg::tap_port_e   port_q;
  pad_tap_pkg::pad_bank_e   bank_q;
  logic [`TURBO_CNT_W-1:0]  turbo_q;

  assign clr_rise = clr & ~clr_q;
  assign sel_rise = sel & ~sel_q;

  // sel only steps the tap when clr is low
  // single pad mode ignores sel edges for porting
  assign port_step = sel_rise & ~clr & tap_enable;

  // line history
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      clr_q <= 1'b0;
      sel_q <= 1'b0;
    end else begin
      clr_q <= clr;
      sel_q <= sel;
    end
  end

  // port counter
  // clr high parks the scan on port 1
  // 3 bit counter, so port 8 rolls over to port 1
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      port_q <= pad_tap_pkg::PORT_1;
    end else if (clr) begin
      port_q <= pad_tap_pkg::PORT_1;
    end else if (port_step) begin
      port_q <= pad_tap_pkg::tap_port_e'(port_q + 1'b1);
    end
  end

  // bank and turbo both step on clr rising
  // bank alternates only in six button mode, otherwise pinned to std
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      bank_q  <= pad_tap_pkg::BANK_STD;
      turbo_q <= '0;
    end else if (clr_rise) begin
      turbo_q <= turbo_q + 1'b1;
      if (six_button_enable && bank_q == pad_tap_pkg::BANK_STD) begin
        bank_q <= pad_tap_pkg::BANK_EXT;
      end else begin
        bank_q <= pad_tap_pkg::BANK_STD;
      end
    end
  end

  assign port_sel     = port_q;
  // bank picks the code half, sel the nibble within it
  assign nibble_idx   = {bank_q, sel_q};
  // registered clr, lines up with the registered sel
  assign nibble_clear = clr_q;
  assign turbo_count  = turbo_q;

endmodule

`default_nettype wire

// File: source/pad_encode.sv
`timescale 1ns/100ps
`default_nettype none

`include "pad_tap_config.svh"

module pad_encode (
  // raw pads, active high
  input  wire pad_tap_pkg::pad_word_t      pad_p1,
  input  wire pad_tap_pkg::pad_word_t      pad_p2,
  input  wire pad_tap_pkg::pad_word_t      pad_p3,
  input  wire pad_tap_pkg::pad_word_t      pad_p4,
  // settings
  input  wire                              six_button_enable,
  input  wire pad_tap_pkg::turbo_speed_e   turbo1_speed,
  input  wire pad_tap_pkg::turbo_speed_e   turbo2_speed,
  input  wire [`TURBO_CNT_W-1:0]           turbo_count,
  // console codes, active low
  output pad_tap_pkg::pad_code_t           code_p1,
  output pad_tap_pkg::pad_code_t           code_p2,
  output pad_tap_pkg::pad_code_t           code_p3,
  output pad_tap_pkg::pad_code_t           code_p4
);

  logic gate_1;
  logic gate_2;
  logic merge;

  // slow and fast tap different counter bits
  // off and the spare code leave the gate open
  function automatic logic turbo_gate(
    input pad_tap_pkg::turbo_speed_e speed,
    input logic [`TURBO_CNT_W-1:0]   count
  );
    logic gate;
    case (speed)
      pad_tap_pkg::TURBO_SLOW: gate = count[`TURBO_SLOW_BIT];
      pad_tap_pkg::TURBO_FAST: gate = count[`TURBO_FAST_BIT];
      default:                 gate = 1'b1;
    endcase
    return gate;
  endfunction

  // III and IV act as turbo I and II
  // then invert and lay out in console nibble order
  function automatic pad_tap_pkg::pad_code_t encode_pad(
    input pad_tap_pkg::pad_word_t pad,
    input logic                   merge_en,
    input logic                   gate_i,
    input logic                   gate_ii
  );
    pad_tap_pkg::pad_word_t p;
    p = pad;
    if (merge_en) begin
      p.btn_1 = pad.btn_1 | (gate_i & pad.btn_3);
      p.btn_2 = pad.btn_2 | (gate_ii & pad.btn_4);
    end
    // top nibble forced high here so it reads zero after the invert
    return ~{{(`PAD_CODE_W - `PAD_BUTTONS){1'b1}},
             p.btn_6, p.btn_5, p.btn_4, p.btn_3,
             p.left, p.down, p.right, p.up,
             p.start, p.select, p.btn_2, p.btn_1};
  endfunction

  assign gate_1 = turbo_gate(turbo1_speed, turbo_count);
  assign gate_2 = turbo_gate(turbo2_speed, turbo_count);

  // six button pads need III and IV as real buttons
  assign merge  = ~six_button_enable;

  assign code_p1 = encode_pad(pad_p1, merge, gate_1, gate_2);
  assign code_p2 = encode_pad(pad_p2, merge, gate_1, gate_2);
  assign code_p3 = encode_pad(pad_p3, merge, gate_1, gate_2);
  assign code_p4 = encode_pad(pad_p4, merge, gate_1, gate_2);

endmodule

`default_nettype wire

// File: source/nibble_select.sv
`timescale 1ns/100ps
`default_nettype none

`include "pad_tap_config.svh"

module nibble_select (
  input  wire                            clk_sys_42_95,
  input  wire                            arst_n,
  // encoded ports
  input  wire pad_tap_pkg::pad_code_t    code_p1,
  input  wire pad_tap_pkg::pad_code_t    code_p2,
  input  wire pad_tap_pkg::pad_code_t    code_p3,
  input  wire pad_tap_pkg::pad_code_t    code_p4,
  // from scan control
  input  wire pad_tap_pkg::tap_port_e    port_sel,
  input  wire [1:0]                      nibble_idx,
  input  wire                            nibble_clear,
  output logic [`NIBBLE_W-1:0]           pad_nibble
);

  localparam int sel_w = $clog2(`TAP_PORTS);

  pad_tap_pkg::pad_code_t [`TAP_PORTS-1:0] codes;
  pad_tap_pkg::pad_code_t                  code_sel;
  logic                                    populated;
  logic [`NIBBLE_W-1:0]                    nibble;

  assign codes = {code_p4, code_p3, code_p2, code_p1};

  // ports 5 to 8 are empty sockets
  assign populated = (port_sel < `TAP_PORTS);

  // all ones reads as nothing pressed
  assign code_sel = populated ? codes[port_sel[sel_w-1:0]] : '1;

  // bank in the upper index bit, sel in the lower
  assign nibble = code_sel[nibble_idx * `NIBBLE_W +: `NIBBLE_W];

  // clr high drives all lines low
  always_ff @(posedge clk_sys_42_95 or negedge arst_n) begin
    if (!arst_n) begin
      pad_nibble <= '0;
    end else if (nibble_clear) begin
      pad_nibble <= '0;
    end else begin
      pad_nibble <= nibble;
    end
  end

endmodule

`default_nettype wire

// File: source/pad_tap_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "pad_tap_config.svh"

module pad_tap_top (
  input  wire                              clk_sys_42_95,
  input  wire                              arst_n,
  // console side
  input  wire                              clr,
  input  wire                              sel,
  // the four pads
  input  wire pad_tap_pkg::pad_word_t      pad_p1,
  input  wire pad_tap_pkg::pad_word_t      pad_p2,
  input  wire pad_tap_pkg::pad_word_t      pad_p3,
  input  wire pad_tap_pkg::pad_word_t      pad_p4,
  // settings
  input  wire                              tap_enable,
  input  wire                              six_button_enable,
  input  wire pad_tap_pkg::turbo_speed_e   turbo1_speed,
  input  wire pad_tap_pkg::turbo_speed_e   turbo2_speed,
  // data lines to the console
  output wire [`NIBBLE_W-1:0]              pad_nibble
);

  // scan control to datapath
  pad_tap_pkg::tap_port_e   port_sel;
  logic [1:0]               nibble_idx;
  logic                     nibble_clear;
  logic [`TURBO_CNT_W-1:0]  turbo_count;

  // encoded ports
  pad_tap_pkg::pad_code_t   code_p1;
  pad_tap_pkg::pad_code_t   code_p2;
  pad_tap_pkg::pad_code_t   code_p3;
  pad_tap_pkg::pad_code_t   code_p4;

  // clr and sel edges, port, bank and turbo
  tap_scan_ctrl u_scan_ctrl (
    .clk_sys_42_95     (clk_sys_42_95),
    .arst_n            (arst_n),
    .clr               (clr),
    .sel               (sel),
    .tap_enable        (tap_enable),
    .six_button_enable (six_button_enable),
    .port_sel          (port_sel),
    .nibble_idx        (nibble_idx),
    .nibble_clear      (nibble_clear),
    .turbo_count       (turbo_count)
  );

  // pads to console codes, no clock
  pad_encode u_encode (
    .pad_p1            (pad_p1),
    .pad_p2            (pad_p2),
    .pad_p3            (pad_p3),
    .pad_p4            (pad_p4),
    .six_button_enable (six_button_enable),
    .turbo1_speed      (turbo1_speed),
    .turbo2_speed      (turbo2_speed),
    .turbo_count       (turbo_count),
    .code_p1           (code_p1),
    .code_p2           (code_p2),
    .code_p3           (code_p3),
    .code_p4           (code_p4)
  );

  // port and nibble mux, output register
  nibble_select u_nibble (
    .clk_sys_42_95 (clk_sys_42_95),
    .arst_n        (arst_n),
    .code_p1       (code_p1),
    .code_p2       (code_p2),
    .code_p3       (code_p3),
    .code_p4       (code_p4),
    .port_sel      (port_sel),
    .nibble_idx    (nibble_idx),
    .nibble_clear  (nibble_clear),
    .pad_nibble    (pad_nibble)
  );

endmodule

`default_nettype wire

// File: dv/pad_tap_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "pad_tap_config.svh"

module pad_tap_tb;

  // one line of the data file
  typedef struct packed {
    logic [15:0]             test_id;
    logic                    clr;
    logic                    sel;
    logic [`PAD_BUTTONS-1:0] p1;
    logic [`PAD_BUTTONS-1:0] p2;
    logic [`PAD_BUTTONS-1:0] p3;
    logic [`PAD_BUTTONS-1:0] p4;
    logic                    tap;
    logic                    six;
    logic [1:0]              turbo1;
    logic [1:0]              turbo2;
    logic [`NIBBLE_W-1:0]    nibble;
  } step_t;

  logic                        clk_sys_42_95;
  logic                        arst_n;
  logic                        clr;
  logic                        sel;
  pad_tap_pkg::pad_word_t      pad_p1;
  pad_tap_pkg::pad_word_t      pad_p2;
  pad_tap_pkg::pad_word_t      pad_p3;
  pad_tap_pkg::pad_word_t      pad_p4;
  logic                        tap_enable;
  logic                        six_button_enable;
  pad_tap_pkg::turbo_speed_e   turbo1_speed;
  pad_tap_pkg::turbo_speed_e   turbo2_speed;
  wire  [`NIBBLE_W-1:0]        pad_nibble;

  // loaded steps and bookkeeping
  step_t steps[$];
  bit    load_ok;
  int    cycle_count;
  int    cycle_limit;
  int    tests_run;
  int    tests_failed;
  int    checks_done;
  int    error_count;
  int    test_errors;
  int    test_steps;

  pad_tap_top u_dut (
    .clk_sys_42_95     (clk_sys_42_95),
    .arst_n            (arst_n),
    .clr               (clr),
    .sel               (sel),
    .pad_p1            (pad_p1),
    .pad_p2            (pad_p2),
    .pad_p3            (pad_p3),
    .pad_p4            (pad_p4),
    .tap_enable        (tap_enable),
    .six_button_enable (six_button_enable),
    .turbo1_speed      (turbo1_speed),
    .turbo2_speed      (turbo2_speed),
    .pad_nibble        (pad_nibble)
  );

  // 100 ns period
  initial begin
    clk_sys_42_95 = 1'b0;
    forever #50 clk_sys_42_95 = ~clk_sys_42_95;
  end

  // watchdog, limit is zero until the steps are loaded
  always @(posedge clk_sys_42_95) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("run timed out after %0d cycles", cycle_count);
      $display("Regression failed");
      $finish;
    end
  end

  // comment lines fail the scan and are skipped
  task automatic load_steps();
    int          fd;
    int          got;
    string       line;
    step_t       s;
    int          id_v, clr_v, sel_v, tap_v, six_v, t1_v, t2_v;
    logic [11:0] p1_v, p2_v, p3_v, p4_v;
    logic [3:0]  nib_v;
    fd = $fopen("dv/pad_testdata.txt", "r");
    if (fd == 0) begin
      load_ok = 1'b0;
      $display("could not open the stimulus file dv/pad_testdata.txt");
    end else begin
      while (!$feof(fd)) begin
        line = "";
        got = $fgets(line, fd);
        got = $sscanf(line, "%d %d %d %h %h %h %h %d %d %d %d %h", id_v, clr_v, sel_v,
                      p1_v, p2_v, p3_v, p4_v, tap_v, six_v, t1_v, t2_v, nib_v);
        if (got == 12) begin
          s = {id_v[15:0], clr_v[0], sel_v[0], p1_v, p2_v, p3_v, p4_v,
               tap_v[0], six_v[0], t1_v[1:0], t2_v[1:0], nib_v};
          steps.push_back(s);
        end
      end
      $fclose(fd);
      load_ok = (steps.size() > 0);
      if (!load_ok) begin
        $display("stimulus file holds no usable step");
      end
    end
  endtask

  task automatic drive_step(input step_t s);
    clr               = s.clr;
    sel               = s.sel;
    pad_p1            = s.p1;
    pad_p2            = s.p2;
    pad_p3            = s.p3;
    pad_p4            = s.p4;
    tap_enable        = s.tap;
    six_button_enable = s.six;
    turbo1_speed      = pad_tap_pkg::turbo_speed_e'(s.turbo1);
    turbo2_speed      = pad_tap_pkg::turbo_speed_e'(s.turbo2);
  endtask

  task automatic check_nibble(input logic [`NIBBLE_W-1:0] expected, input int step_no);
    checks_done++;
    test_steps++;
    if (pad_nibble !== expected) begin
      $display("** Error at %0t ns: pad_nibble expected %h, got %h (step %0d)",
               $time, expected, pad_nibble, step_no);
      test_errors++;
      error_count++;
    end
  endtask

  // one summary line per test id
  task automatic close_test(input int id);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d done: %0d steps, no mismatch", id, test_steps);
    end else begin
      tests_failed++;
      $display("test %0d done: %0d steps, %0d mismatches", id, test_steps, test_errors);
    end
    test_errors = 0;
    test_steps  = 0;
  endtask

  // output settles two cycles after the drive, sampled after four
  task automatic run_steps();
    int i;
    int cur_test;
    cur_test = steps[0].test_id;
    for (i = 0; i < steps.size(); i++) begin
      if (int'(steps[i].test_id) != cur_test) begin
        close_test(cur_test);
        cur_test = steps[i].test_id;
      end
      drive_step(steps[i]);
      repeat (4) @(posedge clk_sys_42_95);
      #10;
      check_nibble(steps[i].nibble, i + 1);
    end
    close_test(cur_test);
  endtask

  initial begin
    arst_n            = 1'b0;
    clr               = 1'b0;
    sel               = 1'b0;
    pad_p1            = '0;
    pad_p2            = '0;
    pad_p3            = '0;
    pad_p4            = '0;
    tap_enable        = 1'b0;
    six_button_enable = 1'b0;
    turbo1_speed      = pad_tap_pkg::TURBO_OFF;
    turbo2_speed      = pad_tap_pkg::TURBO_OFF;
    load_steps();
    cycle_limit = 6 * steps.size() + 50;
    // nibble held at zero during reset
    repeat (5) @(posedge clk_sys_42_95);
    #10;
    check_nibble('0, 0);
    close_test(0);
    arst_n = 1'b1;
    if (load_ok) begin
      run_steps();
    end else begin
      error_count++;
    end
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks_done, error_count);
    if (error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: pad_tap_top.f
+incdir+source
source/pad_tap_pkg.sv
source/tap_scan_ctrl.sv
source/pad_encode.sv
source/nibble_select.sv
source/pad_tap_top.sv
dv/pad_tap_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator from the file list, run, then scan the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f pad_tap_top.f --top-module pad_tap_tb -Mdir obj_dir \
  && ./obj_dir/Vpad_tap_tb > sim.log 2>&1 \
  || { echo "build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "Regression failed" sim.log \
  && { echo "simulation reported a failure, see sim.log"; exit 1; } \
  || { echo "simulation clean"; exit 0; }

// File: dv/pad_testdata.txt
# test clr sel pad_p1 pad_p2 pad_p3 pad_p4 tap six turbo1 turbo2 nibble
# pads and nibble in hex, turbo speed 0 off, 1 slow, 2 fast, 3 off
1 1 0 000 000 000 000 0 0 0 0 0
1 1 1 fff fff fff fff 0 0 0 0 0
1 0 0 000 000 000 000 0 0 0 0 f
2 0 0 0a5 3c3 0ff f00 0 0 0 0 5
2 0 1 0a5 3c3 0ff f00 0 0 0 0 9
2 0 0 0a5 3c3 0ff f00 0 0 0 0 5
2 0 1 0a5 3c3 0ff f00 0 0 0 0 9
2 0 0 0a5 3c3 0ff f00 0 0 0 0 5
3 1 0 012 024 048 081 1 0 0 0 0
3 0 0 012 024 048 081 1 0 0 0 e
3 0 1 012 024 048 081 1 0 0 0 b
3 0 0 012 024 048 081 1 0 0 0 d
3 0 1 012 024 048 081 1 0 0 0 e
3 0 0 012 024 048 081 1 0 0 0 b
3 0 1 012 024 048 081 1 0 0 0 d
3 0 0 012 024 048 081 1 0 0 0 7
3 0 1 012 024 048 081 1 0 0 0 f
3 0 0 012 024 048 081 1 0 0 0 f
3 1 0 012 024 048 081 1 0 0 0 0
3 0 0 012 024 048 081 1 0 0 0 e
4 1 0 5a5 000 000 000 0 1 0 0 0
4 0 0 5a5 000 000 000 0 1 0 0 a
4 0 1 5a5 000 000 000 0 1 0 0 0
4 1 0 5a5 000 000 000 0 1 0 0 0
4 0 0 5a5 000 000 000 0 1 0 0 5
4 0 1 5a5 000 000 000 0 1 0 0 9
4 1 0 5a5 000 000 000 0 1 0 0 0
4 0 0 5a5 000 000 000 0 1 0 0 a
5 1 0 300 000 000 000 0 0 0 0 0
5 0 0 300 000 000 000 0 0 0 0 c
5 0 0 300 000 000 000 0 0 1 2 c
5 1 0 300 000 000 000 0 0 1 2 0
5 0 0 300 000 000 000 0 0 1 2 f
5 1 0 300 000 000 000 0 0 1 2 0
5 0 0 300 000 000 000 0 0 1 2 f
5 1 0 300 000 000 000 0 0 1 2 0
5 0 0 300 000 000 000 0 0 1 2 d
5 0 0 300 000 000 000 0 0 2 1 e
5 0 0 300 000 000 000 0 0 3 3 c
